// ==== compile.f ====
source/umi_pkg.sv
source/umi_cmd_decode.sv
source/umi_regif.sv
source/umi_reg_bank.sv
source/umi_resp_buffer.sv
source/umi_reg_device.sv
testbench/umi_reg_device_assertions.sv
testbench/umi_reg_device_checker.sv
testbench/umi_reg_device_tb.sv

// ==== source/umi_cmd_decode.sv ====
//##################################################
// UMI request command decoder
// Splits the command word into fields, classifies
// the opcode and checks the destination group.
// Purely combinational, feeds the request control
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_cmd_decode
(
   input  wire  [umi_pkg::CW-1:0]           req_cmd,     // Request command word
   input  wire  [umi_pkg::AW-1:0]           req_dstaddr, // Request destination
   output logic                             is_read,     // REQ_READ
   output logic                             is_write,    // REQ_WRITE, needs response
   output logic                             is_posted,   // REQ_POSTED, no response
   output logic                             group_hit,   // Address in our group
   output logic [umi_pkg::SIZE_W-1:0]       size,        // Transfer size code
   output logic [umi_pkg::CW-umi_pkg::OPC_W-1:0] cmd_rest // Command without opcode
);

   umi_pkg::umi_opcode_e opcode;
   logic [umi_pkg::GRP_AW-1:0] group;

   //##################################################
   // Field extraction
   //##################################################
   assign opcode = umi_pkg::umi_opcode_e'(req_cmd[umi_pkg::OPC_W-1:0]);
   assign size = req_cmd[umi_pkg::SIZE_LSB +: umi_pkg::SIZE_W];

   // Everything above the opcode goes back in the response
   assign cmd_rest = req_cmd[umi_pkg::CW-1:umi_pkg::OPC_W];

   //##################################################
   // Opcode class
   //##################################################
   // At most one class flag high at a time
   always_comb
   begin
      is_read = 1'b0;
      is_write = 1'b0;
      is_posted = 1'b0;
      case (opcode)
         umi_pkg::REQ_READ:   is_read = 1'b1;
         umi_pkg::REQ_WRITE:  is_write = 1'b1;
         umi_pkg::REQ_POSTED: is_posted = 1'b1;
         umi_pkg::REQ_RDMA,
         umi_pkg::REQ_ATOMIC:
         begin
            // Recognised but not supported, dropped upstream
            is_read = 1'b0;
         end
         default:
         begin
            // Responses, link, user and unknown codes
            is_read = 1'b0;
         end
      endcase
   end

   //##################################################
   // Group check
   //##################################################
   assign group = req_dstaddr[umi_pkg::GRP_OFFSET +: umi_pkg::GRP_AW];
   assign group_hit = (group == umi_pkg::GRP_ID); // Bits 27:24 match

endmodule

`default_nettype wire

// ==== source/umi_pkg.sv ====
//##################################################
// Shared definitions for the UMI register device
// Opcode enum, command field layout, bus widths
// and register map constants. Referenced by
// scoped names from every RTL block
//##################################################
`default_nettype none

package umi_pkg;

   //##################################################
   // Bus widths
   //##################################################
   localparam int AW = 64;                      // Address width
   localparam int CW = 32;                      // Command width
   localparam int DW = 64;                      // UMI data width
   localparam int RW = 32;                      // Register width
   localparam int BYTES = RW / 8;               // Byte lanes per register

   //##################################################
   // Command word layout
   //##################################################
   // Opcode sits in the lowest bits
   localparam int OPC_W = 5;
   localparam int SIZE_LSB = 5;                 // Size in bits 7:5
   localparam int SIZE_W = 3;

   // Transfer size codes, 3 and up act as word
   localparam logic [SIZE_W-1:0] SIZE_BYTE = 3'd0;
   localparam logic [SIZE_W-1:0] SIZE_HALF = 3'd1;

   // UMI opcodes used or recognised by the device
   typedef enum logic [OPC_W-1:0] {
      REQ_READ   = 5'd1,
      RESP_READ  = 5'd2,
      REQ_WRITE  = 5'd3,
      RESP_WRITE = 5'd4,
      REQ_POSTED = 5'd5,
      REQ_RDMA   = 5'd7,
      REQ_ATOMIC = 5'd9
   } umi_opcode_e;

   //##################################################
   // Address map
   //##################################################
   localparam int GRP_OFFSET = 24;              // Group field position
   localparam int GRP_AW = 4;                   // Group field width
   localparam logic [GRP_AW-1:0] GRP_ID = 4'h3; // Our group

   localparam int REG_COUNT = 8;
   localparam int IDX_W = $clog2(REG_COUNT);    // Register index bits
   localparam int IDX_LSB = 2;                  // Index at addr 4:2
   localparam int LANE_W = 2;                   // Byte lane at addr 1:0

   // Read-only contents of register 0, "UMI" plus version
   localparam logic [RW-1:0] ID_VALUE = 32'h554d4901;

endpackage

`default_nettype wire

// ==== source/umi_reg_bank.sv ====
//##################################################
// Register bank of the UMI device
// Eight 32-bit registers, written per byte lane.
// Register 0 is a fixed ID and ignores writes.
// Read data returns in the access cycle
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_reg_bank
(
   input  wire                           clk,
   input  wire                           nreset,
   input  wire                           wr_en,     // Write this cycle
   input  wire                           rd_en,     // Read this cycle
   input  wire  [umi_pkg::IDX_W-1:0]     index,     // Register select
   input  wire  [umi_pkg::BYTES-1:0]     wr_strobe, // Byte enables
   input  wire  [umi_pkg::RW-1:0]        wr_data,   // Lane-aligned write data
   output logic [umi_pkg::RW-1:0]        rd_data    // Zero unless rd_en
);

   // Register 0 has no storage
   logic [umi_pkg::RW-1:0] regs [1:umi_pkg::REG_COUNT-1];

   //##################################################
   // Write side
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int r = 1; r < umi_pkg::REG_COUNT; r++)
            regs[r] <= '0;
      end
      else if (wr_en)
      begin
         // Only the selected register, only strobed bytes
         for (int r = 1; r < umi_pkg::REG_COUNT; r++)
         begin
            for (int b = 0; b < umi_pkg::BYTES; b++)
            begin
               if (index == umi_pkg::IDX_W'(r) && wr_strobe[b])
                  regs[r][8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
      end
   end

   //##################################################
   // Read side
   //##################################################
   always_comb
   begin
      rd_data = '0;
      if (rd_en)
      begin
         // ID register
         if (index == '0)
            rd_data = umi_pkg::ID_VALUE;
         for (int r = 1; r < umi_pkg::REG_COUNT; r++)
         begin
            if (index == umi_pkg::IDX_W'(r))
               rd_data = regs[r];
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/umi_reg_device.sv ====
//##################################################
// UMI register device, top level
// Request decode, control, register bank and the
// response buffer wired between the two channels
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_reg_device
(
   input  wire                           clk,
   input  wire                           nreset,
   // Request channel
   input  wire                           req_valid,
   input  wire  [umi_pkg::CW-1:0]        req_cmd,
   input  wire  [umi_pkg::AW-1:0]        req_dstaddr,
   input  wire  [umi_pkg::AW-1:0]        req_srcaddr,
   input  wire  [umi_pkg::DW-1:0]        req_data,
   output logic                          req_ready,
   // Response channel
   output logic                          resp_valid,
   output logic [umi_pkg::CW-1:0]        resp_cmd,
   output logic [umi_pkg::AW-1:0]        resp_dstaddr,
   output logic [umi_pkg::AW-1:0]        resp_srcaddr,
   output logic [umi_pkg::DW-1:0]        resp_data,
   input  wire                           resp_ready
);

   // Decode to control
   logic                                 is_read;
   logic                                 is_write;
   logic                                 is_posted;
   logic                                 group_hit;
   logic [umi_pkg::SIZE_W-1:0]           size;
   logic [umi_pkg::CW-umi_pkg::OPC_W-1:0] cmd_rest;
   // Control to bank
   logic                                 wr_en;
   logic                                 rd_en;
   logic [umi_pkg::IDX_W-1:0]            index;
   logic [umi_pkg::BYTES-1:0]            wr_strobe;
   logic [umi_pkg::RW-1:0]               wr_data;
   logic [umi_pkg::RW-1:0]               rd_data;
   // Control to response buffer
   logic                                 push;
   logic [umi_pkg::CW-1:0]               push_cmd;
   logic [umi_pkg::AW-1:0]               push_dstaddr;
   logic [umi_pkg::DW-1:0]               push_data;
   logic                                 full;

   //##################################################
   // Input side
   //##################################################
   umi_cmd_decode umi_cmd_decode_i
   (
      .req_cmd     (req_cmd),
      .req_dstaddr (req_dstaddr),
      .is_read     (is_read),
      .is_write    (is_write),
      .is_posted   (is_posted),
      .group_hit   (group_hit),
      .size        (size),
      .cmd_rest    (cmd_rest)
   );

   //##################################################
   // Request control and registers
   //##################################################
   umi_regif umi_regif_i
   (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .is_read      (is_read),
      .is_write     (is_write),
      .is_posted    (is_posted),
      .group_hit    (group_hit),
      .size         (size),
      .cmd_rest     (cmd_rest),
      .wr_en        (wr_en),
      .rd_en        (rd_en),
      .index        (index),
      .wr_strobe    (wr_strobe),
      .wr_data      (wr_data),
      .rd_data      (rd_data),
      .push         (push),
      .push_cmd     (push_cmd),
      .push_dstaddr (push_dstaddr),
      .push_data    (push_data),
      .full         (full)
   );

   umi_reg_bank umi_reg_bank_i
   (
      .clk       (clk),
      .nreset    (nreset),
      .wr_en     (wr_en),
      .rd_en     (rd_en),
      .index     (index),
      .wr_strobe (wr_strobe),
      .wr_data   (wr_data),
      .rd_data   (rd_data)
   );

   //##################################################
   // Output side
   //##################################################
   umi_resp_buffer umi_resp_buffer_i
   (
      .clk          (clk),
      .nreset       (nreset),
      .push         (push),
      .push_cmd     (push_cmd),
      .push_dstaddr (push_dstaddr),
      .push_data    (push_data),
      .full         (full),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready)
   );

endmodule

`default_nettype wire

// ==== source/umi_regif.sv ====
//##################################################
// UMI request control
// Accepts requests, paces req_ready, turns writes
// into byte strobes for the register bank and
// builds the response pushed to the output buffer
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_regif
(
   input  wire                                   clk,
   input  wire                                   nreset,
   // Request channel
   input  wire                                   req_valid,
   input  wire  [umi_pkg::AW-1:0]                req_dstaddr,
   input  wire  [umi_pkg::AW-1:0]                req_srcaddr,
   input  wire  [umi_pkg::DW-1:0]                req_data,
   output logic                                  req_ready,
   // From decode
   input  wire                                   is_read,
   input  wire                                   is_write,
   input  wire                                   is_posted,
   input  wire                                   group_hit,
   input  wire  [umi_pkg::SIZE_W-1:0]            size,
   input  wire  [umi_pkg::CW-umi_pkg::OPC_W-1:0] cmd_rest,
   // Register bank
   output logic                                  wr_en,
   output logic                                  rd_en,
   output logic [umi_pkg::IDX_W-1:0]             index,
   output logic [umi_pkg::BYTES-1:0]             wr_strobe,
   output logic [umi_pkg::RW-1:0]                wr_data,
   input  wire  [umi_pkg::RW-1:0]                rd_data,
   // Response buffer
   output logic                                  push,
   output logic [umi_pkg::CW-1:0]                push_cmd,
   output logic [umi_pkg::AW-1:0]                push_dstaddr,
   output logic [umi_pkg::DW-1:0]                push_data,
   input  wire                                   full
);

   logic                             rdy_q;       // Low for one cycle after accept
   logic                             accept;      // Request handshake
   logic [umi_pkg::LANE_W-1:0]       lane;
   logic [umi_pkg::BYTES-1:0]        strobe_base; // Strobe before lane shift
   umi_pkg::umi_opcode_e             resp_opcode;

   //##################################################
   // Request pacing
   //##################################################
   // Two-cycle spacing between requests
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rdy_q <= 1'b1;
      else
         rdy_q <= ~accept;
   end

   // Also held off while a response waits for ready
   assign req_ready = rdy_q & ~full;
   assign accept = req_valid & req_ready;

   //##################################################
   // Register access
   //##################################################
   assign lane = req_dstaddr[umi_pkg::LANE_W-1:0];
   assign index = req_dstaddr[umi_pkg::IDX_LSB +: umi_pkg::IDX_W];

   // Out-of-group and unsupported requests touch nothing
   assign rd_en = accept & group_hit & is_read;
   assign wr_en = accept & group_hit & (is_write | is_posted);

   // Lanes covered by the size, aligned at lane 0
   always_comb
   begin
      case (size)
         umi_pkg::SIZE_BYTE: strobe_base = 4'b0001;
         umi_pkg::SIZE_HALF: strobe_base = 4'b0011;
         default:            strobe_base = 4'b1111; // Word and size 3
      endcase
   end

   // Upper lanes fall off past byte 3
   assign wr_strobe = strobe_base << lane;
   assign wr_data = req_data[umi_pkg::RW-1:0] << {lane, 3'b000}; // Low bytes into lane

   //##################################################
   // Response build
   //##################################################
   // Posted writes never get a response
   assign push = accept & group_hit & (is_read | is_write);

   assign resp_opcode = is_read ? umi_pkg::RESP_READ : umi_pkg::RESP_WRITE;
   assign push_cmd = {cmd_rest, resp_opcode};   // Only the opcode changes
   assign push_dstaddr = req_srcaddr;           // Reply goes back to requester

   // Bank drives zero on writes, so write data comes out zero
   assign push_data = {(umi_pkg::DW / umi_pkg::RW){rd_data}};

endmodule

`default_nettype wire

// ==== source/umi_resp_buffer.sv ====
//##################################################
// One-entry UMI response buffer
// Captures a response on push and holds it on the
// response channel until resp_ready is seen
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_resp_buffer
(
   input  wire                           clk,
   input  wire                           nreset,
   // From request control
   input  wire                           push,
   input  wire  [umi_pkg::CW-1:0]        push_cmd,
   input  wire  [umi_pkg::AW-1:0]        push_dstaddr,
   input  wire  [umi_pkg::DW-1:0]        push_data,
   output logic                          full,
   // UMI response channel
   output logic                          resp_valid,
   output logic [umi_pkg::CW-1:0]        resp_cmd,
   output logic [umi_pkg::AW-1:0]        resp_dstaddr,
   output logic [umi_pkg::AW-1:0]        resp_srcaddr,
   output logic [umi_pkg::DW-1:0]        resp_data,
   input  wire                           resp_ready
);

   //##################################################
   // Valid flag
   //##################################################
   // Push only comes while empty, so it wins
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         resp_valid <= 1'b0;
      else if (push)
         resp_valid <= 1'b1;
      else if (resp_ready)
         resp_valid <= 1'b0;   // Handshake or idle
   end

   assign full = resp_valid;

   // Payload, stable until the handshake
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         resp_cmd <= push_cmd;
         resp_dstaddr <= push_dstaddr;
         resp_data <= push_data;
      end
   end

   // Device has no source address of its own
   assign resp_srcaddr = '0;

endmodule

`default_nettype wire

// ==== testbench/umi_reg_device_assertions.sv ====
//##################################################
// Concurrent assertions on the UMI handshakes
// Bound into the register device, watches its
// ports only
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_reg_device_assertions
(
   input wire                        clk,
   input wire                        nreset,
   input wire                        req_valid,
   input wire                        req_ready,
   input wire  [umi_pkg::CW-1:0]     req_cmd,
   input wire  [umi_pkg::AW-1:0]     req_dstaddr,
   input wire                        resp_valid,
   input wire                        resp_ready,
   input wire  [umi_pkg::CW-1:0]     resp_cmd,
   input wire  [umi_pkg::AW-1:0]     resp_dstaddr,
   input wire  [umi_pkg::AW-1:0]     resp_srcaddr,
   input wire  [umi_pkg::DW-1:0]     resp_data
);

   logic needs_resp; // Accepted in-group read or non-posted write

   assign needs_resp = req_valid && req_ready &&
                       (req_dstaddr[27:24] == umi_pkg::GRP_ID) &&
                       (req_cmd[4:0] == umi_pkg::REQ_READ ||
                        req_cmd[4:0] == umi_pkg::REQ_WRITE);

   // Held response keeps every field
   resp_stable: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd) &&
      $stable(resp_dstaddr) && $stable(resp_srcaddr) && $stable(resp_data))
      else $error("Response changed while waiting for ready");

   req_spacing: assert property (@(posedge clk) disable iff (!nreset)
      req_valid && req_ready |=> !req_ready)
      else $error("req_ready high right after an accepted request");

   // Rise only from an accepted request, and always from one
   resp_rise: assert property (@(posedge clk) disable iff (!nreset)
      $rose(resp_valid) |-> $past(needs_resp))
      else $error("resp_valid rose without a request that needs a response");

   resp_latency: assert property (@(posedge clk) disable iff (!nreset)
      needs_resp |=> resp_valid)
      else $error("No response one cycle after an accepted request");

endmodule

`default_nettype wire

// ==== testbench/umi_reg_device_checker.sv ====
//##################################################
// Response checker for the UMI register device
// Models the register bank from the request side,
// queues expected responses and compares each one
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_reg_device_checker
(
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       req_valid,
   input  wire                       req_ready,
   input  wire [umi_pkg::CW-1:0]     req_cmd,
   input  wire [umi_pkg::AW-1:0]     req_dstaddr,
   input  wire [umi_pkg::AW-1:0]     req_srcaddr,
   input  wire [umi_pkg::DW-1:0]     req_data,
   input  wire                       resp_valid,
   input  wire                       resp_ready,
   input  wire [umi_pkg::CW-1:0]     resp_cmd,
   input  wire [umi_pkg::AW-1:0]     resp_dstaddr,
   input  wire [umi_pkg::AW-1:0]     resp_srcaddr,
   input  wire [umi_pkg::DW-1:0]     resp_data,
   output int                        errors,
   output int                        pending       // Responses still owed
);

   localparam int RESP_W = umi_pkg::CW + 2 * umi_pkg::AW;  // cmd, dst, data

   logic [31:0]       model [0:7];
   logic [RESP_W-1:0] expected_q [$];

   // Byte b is written when it lies within size bytes from the lane
   function automatic logic [31:0] apply_write(input logic [31:0] old,
      input logic [31:0] data, input int lane, input logic [2:0] size);
      logic [31:0] result;
      int          nbytes;
      result = old;
      nbytes = (size == 3'd0) ? 1 : (size == 3'd1) ? 2 : 4;
      for (int b = 0; b < 4; b++)
      begin
         if (b >= lane && b < lane + nbytes)
            result[8*b +: 8] = data[8*(b-lane) +: 8];
      end
      return result;
   endfunction

   function automatic logic [RESP_W-1:0] reference_response(
      input logic [31:0] cmd, input logic [63:0] src, input logic [31:0] value,
      input bit is_read);
      logic [31:0] cmd_out;
      cmd_out = cmd;
      cmd_out[4:0] = is_read ? umi_pkg::RESP_READ : umi_pkg::RESP_WRITE;
      return {cmd_out, src, is_read ? {value, value} : 64'h0};
   endfunction

   task automatic compare_field(input string name, input logic [63:0] exp,
      input logic [63:0] got);
      if (exp !== got)
      begin
         errors++;
         $display("FAIL %s expected %h got %h", name, exp, got);
      end
   endtask

   initial
   begin
      errors = 0;
      pending = 0;
      model[0] = umi_pkg::ID_VALUE;
      for (int r = 1; r < 8; r++)
         model[r] = '0;
   end

   always @(posedge clk)
   begin
      logic [RESP_W-1:0] exp;
      logic [4:0]        opc;
      int                idx;
      bit                hit;
      if (nreset)
      begin
         // Response side first, a request never shares its edge
         if (resp_valid && resp_ready)
         begin
            if (expected_q.size() == 0)
            begin
               errors++;
               $display("A response arrived while no response was expected");
            end
            else
            begin
               exp = expected_q.pop_front();
               compare_field("resp_cmd", 64'(exp[RESP_W-1 -: 32]), 64'(resp_cmd));
               compare_field("resp_dstaddr", exp[127:64], resp_dstaddr);
               compare_field("resp_data", exp[63:0], resp_data);
               compare_field("resp_srcaddr", 64'h0, resp_srcaddr);
            end
         end
         if (req_valid && req_ready)
         begin
            // Held response blocks the request channel
            if (resp_valid)
            begin
               errors++;
               $display("A request was accepted while a response was still pending");
            end
            opc = req_cmd[4:0];
            idx = int'(req_dstaddr[4:2]);
            hit = (req_dstaddr[27:24] == 4'h3);
            if (hit && opc == umi_pkg::REQ_READ)
               expected_q.push_back(reference_response(req_cmd, req_srcaddr, model[idx], 1));
            else if (hit && (opc == umi_pkg::REQ_WRITE || opc == umi_pkg::REQ_POSTED))
            begin
               if (idx != 0)   // ID register is read-only
                  model[idx] = apply_write(model[idx], req_data[31:0],
                                           int'(req_dstaddr[1:0]), req_cmd[7:5]);
               if (opc == umi_pkg::REQ_WRITE)
                  expected_q.push_back(reference_response(req_cmd, req_srcaddr, '0, 0));
            end
         end
         pending = expected_q.size();
      end
   end

endmodule

`default_nettype wire

// ==== testbench/umi_reg_device_tb.sv ====
//##################################################
// Testbench for the UMI register device
// Clock, reset, directed and xorshift stimulus on
// the request channel, random resp_ready stalls,
// and the closing result line
//##################################################
`timescale 1ns/1ps
`default_nettype none

module umi_reg_device_tb;

   localparam int WAIT_LIMIT = 1000;  // Cycles per wait loop

   logic                   clk = 1'b0;
   logic                   nreset = 1'b0;
   logic                   req_valid = 1'b0;
   logic [umi_pkg::CW-1:0] req_cmd = '0;
   logic [umi_pkg::AW-1:0] req_dstaddr = '0;
   logic [umi_pkg::AW-1:0] req_srcaddr = '0;
   logic [umi_pkg::DW-1:0] req_data = '0;
   logic                   resp_ready = 1'b0;
   wire                    req_ready;
   wire                    resp_valid;
   wire  [umi_pkg::CW-1:0] resp_cmd;
   wire  [umi_pkg::AW-1:0] resp_dstaddr;
   wire  [umi_pkg::AW-1:0] resp_srcaddr;
   wire  [umi_pkg::DW-1:0] resp_data;

   int          tb_errors = 0;
   int          timeouts = 0;
   int          checker_errors;
   int          checker_pending;
   logic [31:0] rng = 32'h187abc94;
   logic [31:0] ready_rng = 32'h187abc94; // Own stream for resp_ready
   bit          random_ready = 1'b0;   // Stall phase on resp_ready
   int          stretch = 0;

   always #10 clk = ~clk;

   umi_reg_device umi_reg_device_i (.*);

   umi_reg_device_checker checker_i
   (
      .*,
      .errors  (checker_errors),
      .pending (checker_pending)
   );

   bind umi_reg_device umi_reg_device_assertions umi_reg_device_assertions_i (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng = xorshift32(rng);
      r = rng;
   endtask

   //##################################################
   // Request driver
   //##################################################
   // Called 2 ns after an edge, returns 2 ns after the accepting edge
   task automatic send_request(input logic [4:0] opc, input logic [3:0] grp,
      input logic [2:0] idx, input logic [1:0] lane, input logic [2:0] size,
      input logic [31:0] data);
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      int          waited;
      next_rand(r1);
      next_rand(r2);
      next_rand(r3);
      req_cmd = {r1[31:16], 8'h00, size, opc};   // len always 0
      req_dstaddr = {r2, 4'h0, grp, r3[18:0], idx, lane};
      req_srcaddr = {r3, r1};
      req_data = {r2, data};
      req_valid = 1'b1;
      waited = 0;
      while (!req_ready && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         #2;
         waited++;
      end
      if (req_ready)
      begin
         @(posedge clk);   // Handshake edge
         #2;
      end
      else
      begin
         timeouts++;
         $display("Timeout: req_ready stayed low while a request was waiting");
      end
      req_valid = 1'b0;
   endtask

   // Mix of supported, dropped and out-of-group requests
   task automatic random_request();
      logic [31:0] r;
      logic [31:0] d;
      logic [4:0]  opc;
      logic [3:0]  grp;
      next_rand(r);
      next_rand(d);
      case (r[2:0])
         3'd0, 3'd1: opc = umi_pkg::REQ_READ;
         3'd2, 3'd3: opc = umi_pkg::REQ_WRITE;
         3'd4:       opc = umi_pkg::REQ_POSTED;
         3'd5:       opc = umi_pkg::REQ_RDMA;
         3'd6:       opc = umi_pkg::REQ_ATOMIC;
         default:    opc = 5'(r[12:8]);   // Anything at all
      endcase
      grp = (r[7:4] < 4'd13) ? 4'h3 : r[7:4];   // Mostly in group
      send_request(opc, grp, r[15:13], r[17:16], r[20:18], d);
   endtask

   //##################################################
   // Response ready, random stretches in stall phase
   //##################################################
   always @(posedge clk)
   begin
      #2;
      if (!random_ready)
         resp_ready = 1'b1;
      else
      begin
         if (stretch == 0)
         begin
            ready_rng = xorshift32(ready_rng);
            resp_ready = ready_rng[0];
            stretch = 1 + int'(ready_rng[4:1]);
         end
         stretch--;
      end
   end

   //##################################################
   // Test sequence
   //##################################################
   initial
   begin
      logic [31:0] d;
      int          waited;
      repeat (2) @(posedge clk);
      #2;
      nreset = 1'b1;
      if (req_ready !== 1'b1 || resp_valid !== 1'b0)
      begin
         tb_errors++;
         $display("FAIL req_ready/resp_valid after reset expected 1/0 got %h/%h",
                  req_ready, resp_valid);
      end
      send_request(umi_pkg::REQ_READ, 4'h3, 3'd0, 2'd0, 3'd2, 32'h0);   // ID read

      // Every register, lane and size, each write read back
      for (int i = 0; i < 8; i++)
         for (int l = 0; l < 4; l++)
            for (int s = 0; s < 3; s++)
            begin
               next_rand(d);
               send_request(umi_pkg::REQ_WRITE, 4'h3, 3'(i), 2'(l), 3'(s), d);
               send_request(umi_pkg::REQ_READ, 4'h3, 3'(i), 2'd0, 3'd2, 32'h0);
            end

      // Posted writes, size 3 acts as word
      for (int i = 1; i < 8; i++)
      begin
         next_rand(d);
         send_request(umi_pkg::REQ_POSTED, 4'h3, 3'(i), 2'd0, 3'd3, d);
         send_request(umi_pkg::REQ_READ, 4'h3, 3'(i), 2'd0, 3'd2, 32'h0);
      end

      // Dropped requests, then read everything back
      for (int i = 0; i < 8; i++)
      begin
         next_rand(d);
         send_request(umi_pkg::REQ_WRITE, 4'h3 ^ 4'(i + 1), 3'(i), 2'd0, 3'd2, d);
         send_request(umi_pkg::REQ_RDMA, 4'h3, 3'(i), 2'd0, 3'd2, d);
         send_request(umi_pkg::REQ_ATOMIC, 4'h3, 3'(i), 2'd0, 3'd2, ~d);
         send_request(umi_pkg::REQ_READ, 4'h5, 3'(i), 2'd0, 3'd2, 32'h0);
      end
      for (int i = 0; i < 8; i++)
         send_request(umi_pkg::REQ_READ, 4'h3, 3'(i), 2'd0, 3'd2, 32'h0);

      random_ready = 1'b1;
      repeat (300) random_request();
      random_ready = 1'b0;

      // Drain outstanding responses
      waited = 0;
      while ((checker_pending != 0 || resp_valid) && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         #2;
         waited++;
      end
      if (checker_pending != 0 || resp_valid)
      begin
         timeouts++;
         $display("Timeout: expected responses never arrived at the end of the run");
      end
      repeat (2) @(posedge clk);

      $display("Errors: checker %0d, testbench %0d, timeouts %0d",
               checker_errors, tb_errors, timeouts);
      if (checker_errors + tb_errors + timeouts == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire
